// ==== verilog/axi_rd_pkg.sv ====
// AXI read subordinate shared widths, latency, burst and response codes and beat structs
`default_nettype none

package axi_rd_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int BYTE_CNT = DATA_W / 8;
    localparam int BYTE_W   = $clog2(BYTE_CNT);
    localparam int ID_W     = 4;
    localparam int LEN_W    = 8;
    localparam int SIZE_W   = 3;

    // Cycles from an accepted component request to its rdata
    localparam int COMP_LAT   = 2;
    // One skid stage per in-flight beat plus the one issued as room falls
    localparam int SKID_DEPTH = COMP_LAT + 1;

    // ----------------------------------------
    // AXI encodings
    // ----------------------------------------
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10,
        BURST_RSVD  = 2'b11
    } burst_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // ----------------------------------------
    // Channel and pipeline payloads
    // ----------------------------------------
    // AR channel request, 49 bits
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        burst_e            burst;
        logic [SIZE_W-1:0] size;
        logic [LEN_W-1:0]  len;
        logic [ID_W-1:0]   id;
    } ar_req_t;

    // One beat toward the component, byte address, 37 bits
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ID_W-1:0]   id;
        logic              last;
    } comp_req_t;

    // Context riding alongside the component latency
    typedef struct packed {
        logic [ID_W-1:0] id;
        logic            last;
    } beat_ctx_t;

    // R channel beat, 39 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [ID_W-1:0]   id;
        resp_e             resp;
        logic              last;
    } r_beat_t;

endpackage

`default_nettype wire

// ==== verilog/axi_rd_next_addr.sv ====
// Next beat byte address for FIXED, INCR and WRAP bursts
`timescale 1ns/1ps
`default_nettype none

module axi_rd_next_addr import axi_rd_pkg::*; (
    input  wire [ADDR_W-1:0] i_addr,
    input  wire [SIZE_W-1:0] i_size,
    input  wire burst_e      i_burst,
    input  wire [LEN_W-1:0]  i_len,
    output logic [ADDR_W-1:0] o_next_addr
);

    // Bytes per beat and the mask of bits inside one beat
    logic [ADDR_W-1:0] size_bytes;
    logic [ADDR_W-1:0] size_mask;
    // Current address aligned down to the beat size
    logic [ADDR_W-1:0] aligned_addr;
    logic [ADDR_W-1:0] incr_addr;
    // Bits that move inside the wrap window
    logic [ADDR_W-1:0] wrap_mask;

    always_comb begin
        size_bytes   = ADDR_W'(1) << i_size;
        size_mask    = size_bytes - ADDR_W'(1);
        aligned_addr = i_addr & ~size_mask;
        incr_addr    = aligned_addr + size_bytes;
        // Wrap window is (len + 1) beats, a power of two for legal WRAP
        wrap_mask    = ((ADDR_W'(i_len) + ADDR_W'(1)) << i_size) - ADDR_W'(1);
    end

    // ----------------------------------------
    // Burst type select
    // ----------------------------------------
    always_comb begin
        unique case (i_burst)
            BURST_INCR: begin
                o_next_addr = incr_addr;
            end
            BURST_WRAP: begin
                // Upper bits frozen, lower bits roll over at the boundary
                o_next_addr = (aligned_addr & ~wrap_mask) | (incr_addr & wrap_mask);
            end
            default: begin
                // FIXED, and reserved treated as FIXED
                o_next_addr = i_addr;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/axi_rd_decode.sv ====
// AR request capture, burst address stepping and beat down-counter
`timescale 1ns/1ps
`default_nettype none

module axi_rd_decode import axi_rd_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,

    // AR channel
    input  wire         i_arvalid,
    output logic        o_arready,
    input  wire ar_req_t i_ar,

    // Beat handshake with execute
    input  wire         i_beat_accept,
    output logic        o_req_active,
    output comp_req_t   o_req
);

    // Burst context of the active burst
    ar_req_t            ctx_q;
    // Beats left after the current one
    logic [LEN_W-1:0]   cnt_q;
    logic               active_q;
    logic [ADDR_W-1:0]  next_addr;
    logic               ar_hs;
    logic               final_beat;

    // ----------------------------------------
    // AR acceptance
    // ----------------------------------------
    // Final accept frees the context, so a new AR overlaps it
    assign final_beat = i_beat_accept && o_req.last;
    assign o_arready  = !active_q || final_beat;
    assign ar_hs      = i_arvalid && o_arready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
        end else if (ar_hs) begin
            active_q <= 1'b1;
            cnt_q    <= i_ar.len;
        end else if (i_beat_accept) begin
            // Drops after the last request, data may still be in flight
            active_q <= !final_beat;
            // Hold at zero once the burst is done
            cnt_q    <= (cnt_q != '0) ? cnt_q - LEN_W'(1) : cnt_q;
        end
    end

    // Context payload, qualified by active_q
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            ctx_q <= i_ar;
        end else if (i_beat_accept) begin
            ctx_q.addr <= next_addr;
        end
    end

    // ----------------------------------------
    // Address stepping
    // ----------------------------------------
    // Full byte address kept so narrow bursts step correctly
    axi_rd_next_addr u_next_addr (
        .i_addr      (ctx_q.addr),
        .i_size      (ctx_q.size),
        .i_burst     (ctx_q.burst),
        .i_len       (ctx_q.len),
        .o_next_addr (next_addr)
    );

    assign o_req_active = active_q;
    assign o_req.addr   = ctx_q.addr;
    assign o_req.id     = ctx_q.id;
    assign o_req.last   = (cnt_q == '0);

    // Master must keep a stalled AR request valid and unchanged
    ar_held_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        (i_arvalid && !o_arready) |=> (i_arvalid && $stable(i_ar))
    );

endmodule

`default_nettype wire

// ==== verilog/axi_rd_execute.sv ====
// Component request strobe and beat context pipeline across the component latency
`timescale 1ns/1ps
`default_nettype none

module axi_rd_execute import axi_rd_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,

    // From decode
    input  wire              i_req_active,
    input  wire comp_req_t   i_req,
    // Result chain empty
    input  wire              i_room,
    output logic             o_beat_accept,

    // Component request side
    output logic             o_comp_dv,
    output logic [ADDR_W-1:0] o_comp_addr,
    output logic [ID_W-1:0]  o_comp_id,
    output logic             o_comp_last,
    input  wire              i_comp_hld,

    // Toward result in step with returned rdata
    output logic             o_ret_valid,
    output beat_ctx_t        o_ret_ctx
);

    logic [COMP_LAT-1:0] vld_q;
    beat_ctx_t           ctx_q [COMP_LAT];

    // ----------------------------------------
    // Component request
    // ----------------------------------------
    // Issue only when every skid stage can take a beat
    assign o_comp_dv     = i_req_active && i_room;
    assign o_beat_accept = o_comp_dv && !i_comp_hld;
    // Word aligned address to component
    assign o_comp_addr   = {i_req.addr[ADDR_W-1:BYTE_W], BYTE_W'(0)};
    assign o_comp_id     = i_req.id;
    assign o_comp_last   = i_req.last;

    // ----------------------------------------
    // Latency pipeline
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= o_beat_accept;
            for (int i = 1; i < COMP_LAT; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // Beat context, qualified by vld_q
    always_ff @(posedge clk) begin
        ctx_q[0].id   <= i_req.id;
        ctx_q[0].last <= i_req.last;
        for (int i = 1; i < COMP_LAT; i++) begin
            ctx_q[i] <= ctx_q[i-1];
        end
    end

    assign o_ret_valid = vld_q[COMP_LAT-1];
    assign o_ret_ctx   = ctx_q[COMP_LAT-1];

endmodule

`default_nettype wire

// ==== verilog/axi_rd_skid_buffer.sv ====
// One-entry pass-through skid buffer for an R beat
`timescale 1ns/1ps
`default_nettype none

module axi_rd_skid_buffer import axi_rd_pkg::*; (
    input  wire          clk,
    input  wire          rst_n,

    // Upstream
    input  wire          i_valid,
    output logic         o_ready,
    input  wire r_beat_t i_beat,

    // Downstream
    output logic         o_valid,
    input  wire          i_ready,
    output r_beat_t      o_beat
);

    // Stored beat flag and storage
    logic    full_q;
    r_beat_t beat_q;

    // ----------------------------------------
    // Occupancy
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (!full_q && i_valid && !i_ready) begin
            // Downstream stalled, keep the beat
            full_q <= 1'b1;
        end else if (full_q && i_ready) begin
            // Stored beat leaves
            full_q <= 1'b0;
        end
    end

    // Capture only on entering the full state
    always_ff @(posedge clk) begin
        if (!full_q && i_valid && !i_ready) begin
            beat_q <= i_beat;
        end
    end

    // ----------------------------------------
    // Outputs
    // ----------------------------------------
    // No new beat while one is held
    assign o_ready = !full_q;
    // Stored beat takes priority, else pass straight through
    assign o_valid = full_q || i_valid;
    assign o_beat  = full_q ? beat_q : i_beat;

    // A stalled beat stays offered and unchanged
    valid_held_while_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_beat))
    );

endmodule

`default_nettype wire

// ==== verilog/axi_rd_result.sv ====
// R beat formation and skid chain that absorbs R back-pressure
`timescale 1ns/1ps
`default_nettype none

module axi_rd_result import axi_rd_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,

    // Returned beat from execute and the component
    input  wire              i_ret_valid,
    input  wire beat_ctx_t   i_ret_ctx,
    input  wire [DATA_W-1:0] i_comp_rdata,
    input  wire              i_comp_err,
    output logic             o_room,

    // R channel
    output logic             o_rvalid,
    input  wire              i_rready,
    output r_beat_t          o_r
);

    // Index 0 is the chain input, SKID_DEPTH is the R channel
    logic    [SKID_DEPTH:0] vld;
    logic    [SKID_DEPTH:0] rdy;
    r_beat_t [SKID_DEPTH:0] beat;

    // ----------------------------------------
    // Beat formation
    // ----------------------------------------
    assign vld[0]       = i_ret_valid;
    assign beat[0].data = i_comp_rdata;
    assign beat[0].id   = i_ret_ctx.id;
    assign beat[0].resp = i_comp_err ? RESP_SLVERR : RESP_OKAY;
    assign beat[0].last = i_ret_ctx.last;

    // Skid chain, last stage fills first under a stall
    for (genvar g = 0; g < SKID_DEPTH; g++) begin : g_skid
        axi_rd_skid_buffer u_skid (
            .clk     (clk),
            .rst_n   (rst_n),
            .i_valid (vld[g]),
            .o_ready (rdy[g]),
            .i_beat  (beat[g]),
            .o_valid (vld[g+1]),
            .i_ready (rdy[g+1]),
            .o_beat  (beat[g+1])
        );
    end

    assign rdy[SKID_DEPTH] = i_rready;
    assign o_rvalid        = vld[SKID_DEPTH];
    assign o_r             = beat[SKID_DEPTH];
    // Room only when every stage is empty
    assign o_room          = &rdy[SKID_DEPTH-1:0];

    // Issue gating upstream must keep the first stage free for returns
    no_return_into_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        i_ret_valid |-> rdy[0]
    );

endmodule

`default_nettype wire

// ==== verilog/axi_rd_sub.sv ====
// AXI read subordinate top connecting decode, execute and result
`timescale 1ns/1ps
`default_nettype none

module axi_rd_sub import axi_rd_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,

    // AR channel
    input  wire               i_arvalid,
    output logic              o_arready,
    input  wire ar_req_t      i_ar,

    // R channel
    output logic              o_rvalid,
    input  wire               i_rready,
    output r_beat_t           o_r,

    // Component interface
    output logic              o_comp_dv,
    output logic [ADDR_W-1:0] o_comp_addr,
    output logic [ID_W-1:0]   o_comp_id,
    output logic              o_comp_last,
    input  wire               i_comp_hld,
    input  wire [DATA_W-1:0]  i_comp_rdata,
    input  wire               i_comp_err
);

    // ----------------------------------------
    // Internal strobes
    // ----------------------------------------
    logic      req_active;
    comp_req_t req;
    logic      beat_accept;
    logic      room;
    logic      ret_valid;
    beat_ctx_t ret_ctx;

    axi_rd_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_arvalid     (i_arvalid),
        .o_arready     (o_arready),
        .i_ar          (i_ar),
        .i_beat_accept (beat_accept),
        .o_req_active  (req_active),
        .o_req         (req)
    );

    axi_rd_execute u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_req_active  (req_active),
        .i_req         (req),
        .i_room        (room),
        .o_beat_accept (beat_accept),
        .o_comp_dv     (o_comp_dv),
        .o_comp_addr   (o_comp_addr),
        .o_comp_id     (o_comp_id),
        .o_comp_last   (o_comp_last),
        .i_comp_hld    (i_comp_hld),
        .o_ret_valid   (ret_valid),
        .o_ret_ctx     (ret_ctx)
    );

    axi_rd_result u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ret_valid  (ret_valid),
        .i_ret_ctx    (ret_ctx),
        .i_comp_rdata (i_comp_rdata),
        .i_comp_err   (i_comp_err),
        .o_room       (room),
        .o_rvalid     (o_rvalid),
        .i_rready     (i_rready),
        .o_r          (o_r)
    );

endmodule

`default_nettype wire

// ==== sim/axi_rd_mem_model.sv ====
// Fixed-latency register component model with a periodic hold and an error window
`timescale 1ns/1ps
`default_nettype none

module axi_rd_mem_model import axi_rd_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               i_dv,
    input  wire [ADDR_W-1:0]  i_addr,
    output logic              o_hld,
    output logic [DATA_W-1:0] o_rdata,
    output logic              o_err
);

    logic [1:0]          hld_cnt_q;
    // Accepted request flags across the latency
    logic [COMP_LAT-1:0] acc_q;
    logic [ADDR_W-1:0]   addr_q [COMP_LAT];
    logic [ADDR_W-1:0]   word_addr;

    // Free-running mod-3 counter that holds on every third cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hld_cnt_q <= '0;
        end else if (hld_cnt_q == 2'd2) begin
            hld_cnt_q <= '0;
        end else begin
            hld_cnt_q <= hld_cnt_q + 2'd1;
        end
    end

    assign o_hld = (hld_cnt_q == 2'd2);

    // A request counts only when dv is high and hold is low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else begin
            acc_q[0] <= i_dv && !o_hld;
            for (int i = 1; i < COMP_LAT; i++) begin
                acc_q[i] <= acc_q[i-1];
            end
        end
    end

    // Address pipe in step with acc_q
    always_ff @(posedge clk) begin
        addr_q[0] <= i_addr;
        for (int i = 1; i < COMP_LAT; i++) begin
            addr_q[i] <= addr_q[i-1];
        end
    end

    // ----------------------------------------
    // Read data and error window
    // ----------------------------------------
    assign word_addr = {addr_q[COMP_LAT-1][ADDR_W-1:BYTE_W], BYTE_W'(0)};
    // Upper half inverted so data never equals the address
    // Zero outside the return cycle
    assign o_rdata   = acc_q[COMP_LAT-1] ? {~word_addr[31:16], word_addr[15:0]} : '0;
    assign o_err     = acc_q[COMP_LAT-1] && (word_addr[15:12] == 4'hE);

endmodule

`default_nettype wire

// ==== sim/tb_axi_rd_sub.sv ====
// Testbench for the AXI read subordinate with a burst table, random R stalls and a beat checker
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rd_sub import axi_rd_pkg::*; ();

    localparam int          WAIT_LIMIT = 200;
    localparam logic [31:0] SEED       = 32'h2e0add7c;

    // One table row with its expected SLVERR beat count
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        burst_e            burst;
        logic [SIZE_W-1:0] size;
        logic [LEN_W-1:0]  len;
        logic [ID_W-1:0]   id;
        logic [7:0]        err_beats;
    } burst_row_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              arvalid;
    logic              arready;
    ar_req_t           ar;
    logic              rvalid;
    logic              rready;
    r_beat_t           r;
    logic              comp_dv;
    logic [ADDR_W-1:0] comp_addr;
    logic [ID_W-1:0]   comp_id;
    logic              comp_last;
    logic              comp_hld;
    logic [DATA_W-1:0] comp_rdata;
    logic              comp_err;

    burst_row_t        bursts[$];
    logic [31:0]       rng_q;
    int                error_cnt;
    int                req_err_cnt;
    int                beat_cnt;

    always #5 clk = ~clk;

    axi_rd_sub i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_arvalid    (arvalid),
        .o_arready    (arready),
        .i_ar         (ar),
        .o_rvalid     (rvalid),
        .i_rready     (rready),
        .o_r          (r),
        .o_comp_dv    (comp_dv),
        .o_comp_addr  (comp_addr),
        .o_comp_id    (comp_id),
        .o_comp_last  (comp_last),
        .i_comp_hld   (comp_hld),
        .i_comp_rdata (comp_rdata),
        .i_comp_err   (comp_err)
    );

    axi_rd_mem_model u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_dv    (comp_dv),
        .i_addr  (comp_addr),
        .o_hld   (comp_hld),
        .o_rdata (comp_rdata),
        .o_err   (comp_err)
    );

    // ----------------------------------------
    // Reference rules
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Byte address of the beat after a
    function automatic logic [ADDR_W-1:0] step_addr(input burst_row_t row,
                                                     input logic [ADDR_W-1:0] a);
        logic [ADDR_W-1:0] nbytes;
        logic [ADDR_W-1:0] aligned;
        logic [ADDR_W-1:0] span;
        logic [ADDR_W-1:0] base;
        nbytes  = 32'd1 << row.size;
        aligned = (a / nbytes) * nbytes;
        // Wrap span and its start below the aligned address
        span    = nbytes * ({24'd0, row.len} + 32'd1);
        base    = (aligned / span) * span;
        case (row.burst)
            BURST_INCR: return aligned + nbytes;
            BURST_WRAP: return base + ((aligned - base + nbytes) % span);
            default:    return a;
        endcase
    endfunction

    // Start of the word that holds byte address a
    function automatic logic [ADDR_W-1:0] word_of(input logic [ADDR_W-1:0] a);
        return (a / ADDR_W'(BYTE_CNT)) * ADDR_W'(BYTE_CNT);
    endfunction

    function automatic logic [DATA_W-1:0] expected_data(input logic [ADDR_W-1:0] a);
        logic [ADDR_W-1:0] word;
        word = word_of(a);
        return {~word[31:16], word[15:0]};
    endfunction

    function automatic logic in_err_window(input logic [ADDR_W-1:0] a);
        return a[15:12] == 4'hE;
    endfunction

    // ----------------------------------------
    // Burst table
    // ----------------------------------------
    task automatic add_burst(input logic [ADDR_W-1:0] addr, input burst_e burst,
                             input logic [SIZE_W-1:0] size, input logic [LEN_W-1:0] len,
                             input logic [ID_W-1:0] id, input logic [7:0] err_beats);
        burst_row_t row;
        row.addr      = addr;
        row.burst     = burst;
        row.size      = size;
        row.len       = len;
        row.id        = id;
        row.err_beats = err_beats;
        bursts.push_back(row);
    endtask

    task automatic load_table();
        // INCR word bursts of 1, 4 and 16 beats
        add_burst(32'h0000_1000, BURST_INCR,  3'd2, 8'd0,  4'h1, 8'd0);
        add_burst(32'h0000_2010, BURST_INCR,  3'd2, 8'd3,  4'h2, 8'd0);
        add_burst(32'h0001_3000, BURST_INCR,  3'd2, 8'd15, 4'h3, 8'd0);
        // WRAP starting mid-boundary, then FIXED
        add_burst(32'h0000_4038, BURST_WRAP,  3'd2, 8'd3,  4'h4, 8'd0);
        add_burst(32'h0000_5054, BURST_WRAP,  3'd2, 8'd7,  4'h5, 8'd0);
        add_burst(32'h0000_6100, BURST_FIXED, 3'd2, 8'd3,  4'h6, 8'd0);
        // Narrow byte and halfword bursts
        add_burst(32'h0000_7003, BURST_INCR,  3'd0, 8'd7,  4'h7, 8'd0);
        add_burst(32'h0000_8006, BURST_INCR,  3'd1, 8'd5,  4'h8, 8'd0);
        // Half inside and fully inside the error window
        add_burst(32'h0000_eff0, BURST_INCR,  3'd2, 8'd7,  4'h9, 8'd4);
        add_burst(32'h0001_e000, BURST_INCR,  3'd2, 8'd3,  4'ha, 8'd4);
        add_burst(32'h0000_9024, BURST_WRAP,  3'd2, 8'd15, 4'hb, 8'd0);
        add_burst(32'h0000_0000, BURST_INCR,  3'd2, 8'd0,  4'h0, 8'd0);
    endtask

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("Done: errors found");
        $finish;
    endtask

    // ----------------------------------------
    // Back-to-back AR driver
    // ----------------------------------------
    task automatic drive_bursts();
        ar_req_t req;
        int      wait_cnt;
        for (int i = 0; i < bursts.size(); i++) begin
            req.addr  = bursts[i].addr;
            req.burst = bursts[i].burst;
            req.size  = bursts[i].size;
            req.len   = bursts[i].len;
            req.id    = bursts[i].id;
            ar        = req;
            arvalid   = 1'b1;
            wait_cnt  = 0;
            @(negedge clk);
            while (!arready) begin
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) begin
                    abort_run("AR request was never accepted");
                end
                @(negedge clk);
            end
            // Handshake lands on this edge
            @(posedge clk);
            #1;
        end
        arvalid = 1'b0;
    endtask

    // ----------------------------------------
    // Component request checker
    // ----------------------------------------
    task automatic verify_requests();
        burst_row_t        row;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] exp_addr;
        logic              exp_last;
        int                wait_cnt;
        for (int i = 0; i < bursts.size(); i++) begin
            row  = bursts[i];
            addr = row.addr;
            for (int b = 0; b <= int'(row.len); b++) begin
                wait_cnt = 0;
                @(negedge clk);
                while (!(comp_dv && !comp_hld)) begin
                    wait_cnt++;
                    if (wait_cnt > WAIT_LIMIT) begin
                        abort_run("a component request of a pending burst was never issued");
                    end
                    @(negedge clk);
                end
                exp_addr = word_of(addr);
                exp_last = (b == int'(row.len));
                if (comp_addr !== exp_addr) begin
                    $display("mismatch o_comp_addr burst %0d beat %0d: got %h, expected %h",
                             i, b, comp_addr, exp_addr);
                    req_err_cnt++;
                end
                if (comp_id !== row.id) begin
                    $display("mismatch o_comp_id burst %0d beat %0d: got %h, expected %h",
                             i, b, comp_id, row.id);
                    req_err_cnt++;
                end
                if (comp_last !== exp_last) begin
                    $display("mismatch o_comp_last burst %0d beat %0d: got %h, expected %h",
                             i, b, comp_last, exp_last);
                    req_err_cnt++;
                end
                addr = step_addr(row, addr);
            end
        end
        $display("component requests: %s", (req_err_cnt == 0) ? "pass" : "fail");
    endtask

    // ----------------------------------------
    // R beat checker
    // ----------------------------------------
    task automatic check_bursts();
        burst_row_t        row;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] exp_data;
        resp_e             exp_resp;
        logic              exp_last;
        int                wait_cnt;
        int                errs_before;
        int                slverr_cnt;
        for (int i = 0; i < bursts.size(); i++) begin
            row         = bursts[i];
            addr        = row.addr;
            errs_before = error_cnt;
            slverr_cnt  = 0;
            for (int b = 0; b <= int'(row.len); b++) begin
                wait_cnt = 0;
                @(negedge clk);
                while (!(rvalid && rready)) begin
                    wait_cnt++;
                    if (wait_cnt > WAIT_LIMIT) begin
                        abort_run("an R beat of a pending burst never arrived");
                    end
                    @(negedge clk);
                end
                exp_data = expected_data(addr);
                exp_resp = in_err_window(addr) ? RESP_SLVERR : RESP_OKAY;
                exp_last = (b == int'(row.len));
                if (r.data !== exp_data) begin
                    $display("mismatch o_r.data burst %0d beat %0d: got %h, expected %h",
                             i, b, r.data, exp_data);
                    error_cnt++;
                end
                if (r.id !== row.id) begin
                    $display("mismatch o_r.id burst %0d beat %0d: got %h, expected %h",
                             i, b, r.id, row.id);
                    error_cnt++;
                end
                if (r.resp !== exp_resp) begin
                    $display("mismatch o_r.resp burst %0d beat %0d: got %h, expected %h",
                             i, b, r.resp, exp_resp);
                    error_cnt++;
                end
                if (r.last !== exp_last) begin
                    $display("mismatch o_r.last burst %0d beat %0d: got %h, expected %h",
                             i, b, r.last, exp_last);
                    error_cnt++;
                end
                if (r.resp == RESP_SLVERR) begin
                    slverr_cnt++;
                end
                beat_cnt++;
                addr = step_addr(row, addr);
            end
            if (slverr_cnt != int'(row.err_beats)) begin
                $display("burst %0d returned %0d SLVERR beats but the table expects %0d",
                         i, slverr_cnt, row.err_beats);
                error_cnt++;
            end
            $display("burst %0d id %h len %0d: %s", i, row.id, row.len,
                     (error_cnt == errs_before) ? "pass" : "fail");
        end
    endtask

    // R stalls in about a third of cycles
    initial begin
        rready = 1'b0;
        rng_q  = SEED;
        forever begin
            @(posedge clk);
            #1;
            rng_q  = xorshift32(rng_q);
            rready = (rng_q % 32'd3) != 32'd0;
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int errs_before;
        rst_n       = 1'b0;
        arvalid     = 1'b0;
        ar          = '0;
        error_cnt   = 0;
        req_err_cnt = 0;
        beat_cnt    = 0;
        load_table();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle outputs before the first burst
        @(negedge clk);
        if (rvalid !== 1'b0) begin
            $display("mismatch o_rvalid after reset: got %h, expected %h", rvalid, 1'b0);
            error_cnt++;
        end
        if (arready !== 1'b1) begin
            $display("mismatch o_arready after reset: got %h, expected %h", arready, 1'b1);
            error_cnt++;
        end
        if (comp_dv !== 1'b0) begin
            $display("mismatch o_comp_dv after reset: got %h, expected %h", comp_dv, 1'b0);
            error_cnt++;
        end
        $display("reset state: %s", (error_cnt == 0) ? "pass" : "fail");

        @(posedge clk);
        #1;
        fork
            drive_bursts();
            verify_requests();
            check_bursts();
        join
        error_cnt = error_cnt + req_err_cnt;

        // Nothing more may come out once every burst is done
        errs_before = error_cnt;
        for (int c = 0; c < 20; c++) begin
            @(negedge clk);
            if (rvalid) begin
                $display("an extra R beat with id %h came after the last burst", r.id);
                error_cnt++;
            end
        end
        $display("drain: %s", (error_cnt == errs_before) ? "pass" : "fail");

        $display("bursts %0d, beats %0d, errors %0d", bursts.size(), beat_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/axi_rd_pkg.sv
verilog/axi_rd_next_addr.sv
verilog/axi_rd_decode.sv
verilog/axi_rd_execute.sv
verilog/axi_rd_skid_buffer.sv
verilog/axi_rd_result.sv
verilog/axi_rd_sub.sv
sim/axi_rd_mem_model.sv
sim/tb_axi_rd_sub.sv

// ==== Makefile ====
# Verilator simulation of the AXI read subordinate

TOP := tb_axi_rd_sub

.PHONY: sim clean

# Build, run, then pass only if the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sources.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
